// File: hw/axi_slave_pkg.sv
/* AXI memory slave shared types */

package axi_slave_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;   // beats minus one
  typedef logic [2:0]        size_t;  // log2 of bytes per beat

  typedef enum logic [1:0] {BURST_FIXED = 2'b00, BURST_INCR = 2'b01, BURST_WRAP = 2'b10} burst_t;
  typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10, RESP_DECERR = 2'b11} resp_t;
  typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic {RD_ADDR, RD_DATA} rd_state_t;

  // one response for the whole burst, decided at address time
  function automatic resp_t burst_resp(addr_t addr, len_t len, size_t size, burst_t burst,
                                       int unsigned mem_bytes);
    longint unsigned beat_bytes;
    longint unsigned span;
    longint unsigned lo;
    if (size > 3'd2) return RESP_SLVERR;
    beat_bytes = 64'd1 << size;
    if ((64'(addr) & (beat_bytes - 64'd1)) != 64'd0) return RESP_SLVERR;
    span = (64'(len) + 64'd1) * beat_bytes;
    lo   = 64'(addr);
    case (burst)
      BURST_FIXED: span = beat_bytes;  // same bytes every beat
      BURST_INCR:  ;
      BURST_WRAP: begin
        if (!(len inside {4'd1, 4'd3, 4'd7, 4'd15})) return RESP_SLVERR;
        lo = lo & ~(span - 64'd1);     // aligned wrap window
      end
      default: return RESP_SLVERR;
    endcase
    if (lo + span > 64'(mem_bytes)) return RESP_DECERR;
    return RESP_OKAY;
  endfunction

endpackage

// File: hw/burst_addr_gen.sv
/* Burst beat address generator */

`timescale 1ns/1ps

module burst_addr_gen (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 load,
  input  axi_slave_pkg::addr_t start_addr,
  input  axi_slave_pkg::len_t  len,
  input  axi_slave_pkg::size_t size,
  input  axi_slave_pkg::burst_t burst,
  input  logic                 step,
  output axi_slave_pkg::addr_t addr
);
  import axi_slave_pkg::*;

  len_t   len_q;
  size_t  size_q;
  burst_t burst_q;
  addr_t  incr;
  addr_t  wrap_mask;
  addr_t  next_addr;

  assign incr      = addr_t'(1) << size_q;
  assign wrap_mask = ((addr_t'(len_q) + addr_t'(1)) << size_q) - addr_t'(1);

  always_comb begin
    case (burst_q)
      BURST_INCR: next_addr = addr + incr;
      BURST_WRAP: next_addr = (addr & ~wrap_mask) | ((addr + incr) & wrap_mask);
      default:    next_addr = addr;  // fixed keeps the address
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      addr    <= '0;
      len_q   <= '0;
      size_q  <= '0;
      burst_q <= BURST_FIXED;
    end else if (load) begin
      addr    <= start_addr;
      len_q   <= len;
      size_q  <= size;
      burst_q <= burst;
    end else if (step) begin
      addr <= next_addr;
    end
  end

  // channels only load bursts that passed the response check
  a_wrap_len: assert property (@(posedge clk) disable iff (!resetn)
    (load && burst == BURST_WRAP) |-> (len inside {4'd1, 4'd3, 4'd7, 4'd15}))
    else $error("wrap burst loaded with an illegal length");

endmodule

// File: hw/byte_mem.sv
/* Byte-addressed burst memory */

`timescale 1ns/1ps

module byte_mem #(
  parameter int unsigned MEM_BYTES = 128
) (
  input  logic                 clk,
  input  logic                 we,
  input  axi_slave_pkg::addr_t waddr,
  input  axi_slave_pkg::data_t wdata,
  input  axi_slave_pkg::strb_t wstrb,
  input  axi_slave_pkg::size_t wsize,
  input  axi_slave_pkg::addr_t raddr,
  input  axi_slave_pkg::size_t rsize,
  output axi_slave_pkg::data_t rdata
);
  import axi_slave_pkg::*;

  localparam int IDX_W = $clog2(MEM_BYTES);

  logic [7:0] mem [MEM_BYTES];

  function automatic logic [IDX_W-1:0] lane_idx(addr_t base, int lane);
    addr_t a;
    a = base + addr_t'(lane);
    return a[IDX_W-1:0];
  endfunction

  initial begin
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  //////////////////////////////
  // strobed write, lane k at waddr+k
  always @(posedge clk) begin
    if (we) begin
      for (int k = 0; k < STRB_W; k++) begin
        if (k < (1 << wsize) && wstrb[k]) begin
          mem[lane_idx(waddr, k)] <= wdata[8*k +: 8];
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < STRB_W; k++) begin
      rdata[8*k +: 8] = (k < (1 << rsize)) ? mem[lane_idx(raddr, k)] : 8'h00;  // unused lanes zero
    end
  end

  a_write_in_range: assert property (@(posedge clk)
    we |-> (64'(waddr) + (64'd1 << wsize)) <= 64'(MEM_BYTES))
    else $error("memory write beyond the end of the array");

endmodule

// File: hw/write_channel.sv
/* AXI write channel control */

`timescale 1ns/1ps

module write_channel #(
  parameter int unsigned MEM_BYTES = 128
) (
  input  logic                   clk,
  input  logic                   resetn,
  // aw channel
  input  logic                   awvalid,
  output logic                   awready,
  input  axi_slave_pkg::id_t     awid,
  input  axi_slave_pkg::addr_t   awaddr,
  input  axi_slave_pkg::len_t    awlen,
  input  axi_slave_pkg::size_t   awsize,
  input  axi_slave_pkg::burst_t  awburst,
  // w channel
  input  logic                   wvalid,
  output logic                   wready,
  input  axi_slave_pkg::data_t   wdata,
  input  axi_slave_pkg::strb_t   wstrb,
  input  logic                   wlast,
  // b channel
  output logic                   bvalid,
  input  logic                   bready,
  output axi_slave_pkg::id_t     bid,
  output axi_slave_pkg::resp_t   bresp,
  // memory write port
  output logic                   mem_we,
  output axi_slave_pkg::addr_t   mem_waddr,
  output axi_slave_pkg::data_t   mem_wdata,
  output axi_slave_pkg::strb_t   mem_wstrb,
  output axi_slave_pkg::size_t   mem_wsize
);
  import axi_slave_pkg::*;

  wr_state_t state;
  id_t       id_q;
  size_t     size_q;
  resp_t     resp_q;
  len_t      len_q;
  len_t      beat_cnt;
  resp_t     aw_resp;
  logic      aw_fire;
  logic      w_fire;
  logic      last_beat;

  assign aw_resp   = burst_resp(awaddr, awlen, awsize, awburst, MEM_BYTES);
  assign awready   = resetn && (state == WR_ADDR);  // low while in reset
  assign wready    = (state == WR_DATA);
  assign bvalid    = (state == WR_RESP);
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign last_beat = (beat_cnt == len_q);

  assign bid       = id_q;
  assign bresp     = resp_q;
  assign mem_we    = w_fire && (resp_q == RESP_OKAY);  // error bursts write nothing
  assign mem_wdata = wdata;
  assign mem_wstrb = wstrb;
  assign mem_wsize = size_q;

  burst_addr_gen i_burst_addr_gen (
    .clk        (clk),
    .resetn     (resetn),
    .load       (aw_fire && aw_resp == RESP_OKAY),
    .start_addr (awaddr),
    .len        (awlen),
    .size       (awsize),
    .burst      (awburst),
    .step       (w_fire),
    .addr       (mem_waddr)
  );

  //////////////////////////////
  // write FSM
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= WR_ADDR;
      len_q    <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        WR_ADDR: begin
          if (aw_fire) begin
            state    <= WR_DATA;
            len_q    <= awlen;
            beat_cnt <= '0;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            if (last_beat) state <= WR_RESP;
            else beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: if (bready) state <= WR_ADDR;  // b transfer
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= awid;
      size_q <= awsize;
      resp_q <= aw_resp;
    end
  end

  a_wlast: assert property (@(posedge clk) disable iff (!resetn) w_fire |-> (wlast == last_beat))
    else $error("wlast does not match the counted last beat");

endmodule

// File: hw/read_channel.sv
/* AXI read channel control */

`timescale 1ns/1ps

module read_channel #(
  parameter int unsigned MEM_BYTES = 128
) (
  input  logic                   clk,
  input  logic                   resetn,
  // ar channel
  input  logic                   arvalid,
  output logic                   arready,
  input  axi_slave_pkg::id_t     arid,
  input  axi_slave_pkg::addr_t   araddr,
  input  axi_slave_pkg::len_t    arlen,
  input  axi_slave_pkg::size_t   arsize,
  input  axi_slave_pkg::burst_t  arburst,
  // r channel
  output logic                   rvalid,
  input  logic                   rready,
  output axi_slave_pkg::id_t     rid,
  output axi_slave_pkg::data_t   rdata,
  output axi_slave_pkg::resp_t   rresp,
  output logic                   rlast,
  // memory read port
  output axi_slave_pkg::addr_t   mem_raddr,
  output axi_slave_pkg::size_t   mem_rsize,
  input  axi_slave_pkg::data_t   mem_rdata
);
  import axi_slave_pkg::*;

  rd_state_t state;
  id_t       id_q;
  size_t     size_q;
  resp_t     resp_q;
  len_t      len_q;
  len_t      beat_cnt;
  resp_t     ar_resp;
  logic      ar_fire;
  logic      r_fire;
  logic      held;       // stalled beat captured
  data_t     hold_data;
  data_t     live_data;

  assign ar_resp   = burst_resp(araddr, arlen, arsize, arburst, MEM_BYTES);
  assign arready   = resetn && (state == RD_ADDR);  // low while in reset
  assign rvalid    = (state == RD_DATA);
  assign ar_fire   = arvalid && arready;
  assign r_fire    = rvalid && rready;

  assign rid       = id_q;
  assign rresp     = resp_q;
  assign rlast     = rvalid && (beat_cnt == len_q);
  assign mem_rsize = size_q;
  assign live_data = (resp_q == RESP_OKAY) ? mem_rdata : '0;  // zero for error bursts
  // a concurrent write must not disturb a stalled beat
  assign rdata     = held ? hold_data : live_data;

  burst_addr_gen i_burst_addr_gen (
    .clk        (clk),
    .resetn     (resetn),
    .load       (ar_fire && ar_resp == RESP_OKAY),
    .start_addr (araddr),
    .len        (arlen),
    .size       (arsize),
    .burst      (arburst),
    .step       (r_fire),
    .addr       (mem_raddr)
  );

  //////////////////////////////
  // read FSM
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state    <= RD_ADDR;
      len_q    <= '0;
      beat_cnt <= '0;
      held     <= 1'b0;
    end else begin
      held <= rvalid && !rready;
      case (state)
        RD_ADDR: begin
          if (ar_fire) begin
            state    <= RD_DATA;
            len_q    <= arlen;
            beat_cnt <= '0;
          end
        end
        default: begin
          if (r_fire) begin
            if (rlast) state <= RD_ADDR;
            else beat_cnt <= beat_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= arid;
      size_q <= arsize;
      resp_q <= ar_resp;
    end
    if (rvalid && !rready) hold_data <= rdata;
  end

  a_rdata_hold: assert property (@(posedge clk) disable iff (!resetn)
    (rvalid && !rready) |=> $stable(rdata))
    else $error("rdata changed while the beat was stalled");

endmodule

// File: hw/axi_mem_slave.sv
/* AXI memory slave top */

`timescale 1ns/1ps

module axi_mem_slave #(
  parameter int unsigned MEM_BYTES = 128
) (
  input  logic clk,
  input  logic resetn,
  input  logic awvalid,
  output logic awready,
  input  axi_slave_pkg::id_t    awid,
  input  axi_slave_pkg::addr_t  awaddr,
  input  axi_slave_pkg::len_t   awlen,
  input  axi_slave_pkg::size_t  awsize,
  input  axi_slave_pkg::burst_t awburst,
  input  logic wvalid,
  output logic wready,
  input  axi_slave_pkg::data_t  wdata,
  input  axi_slave_pkg::strb_t  wstrb,
  input  logic wlast,
  output logic bvalid,
  input  logic bready,
  output axi_slave_pkg::id_t    bid,
  output axi_slave_pkg::resp_t  bresp,
  input  logic arvalid,
  output logic arready,
  input  axi_slave_pkg::id_t    arid,
  input  axi_slave_pkg::addr_t  araddr,
  input  axi_slave_pkg::len_t   arlen,
  input  axi_slave_pkg::size_t  arsize,
  input  axi_slave_pkg::burst_t arburst,
  output logic rvalid,
  input  logic rready,
  output axi_slave_pkg::id_t    rid,
  output axi_slave_pkg::data_t  rdata,
  output axi_slave_pkg::resp_t  rresp,
  output logic rlast
);
  import axi_slave_pkg::*;

  logic  mem_we;
  addr_t mem_waddr;
  data_t mem_wdata;
  strb_t mem_wstrb;
  size_t mem_wsize;
  addr_t mem_raddr;
  size_t mem_rsize;
  data_t mem_rdata;

  write_channel #(.MEM_BYTES(MEM_BYTES)) i_write_channel (
    .clk(clk), .resetn(resetn),
    .awvalid(awvalid), .awready(awready), .awid(awid), .awaddr(awaddr),
    .awlen(awlen), .awsize(awsize), .awburst(awburst),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
    .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
    .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb), .mem_wsize(mem_wsize)
  );

  read_channel #(.MEM_BYTES(MEM_BYTES)) i_read_channel (
    .clk(clk), .resetn(resetn),
    .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
    .arlen(arlen), .arsize(arsize), .arburst(arburst),
    .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata),
    .rresp(rresp), .rlast(rlast),
    .mem_raddr(mem_raddr), .mem_rsize(mem_rsize), .mem_rdata(mem_rdata)
  );

  byte_mem #(.MEM_BYTES(MEM_BYTES)) i_byte_mem (
    .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
    .wstrb(mem_wstrb), .wsize(mem_wsize),
    .raddr(mem_raddr), .rsize(mem_rsize), .rdata(mem_rdata)
  );

endmodule

// File: tb/axi_mem_model.svh
/* Memory reference model and compares */

`ifndef AXI_MEM_MODEL_SVH
`define AXI_MEM_MODEL_SVH

logic [7:0] model_mem [MEM_BYTES];

//////////////////////////////
// response rule, checked in order
function automatic resp_t expected_resp(addr_t addr, len_t len, size_t size, burst_t burst);
  longint unsigned bytes;
  longint unsigned beats;
  longint unsigned lo;
  longint unsigned hi;
  if (size > 3'd2) return RESP_SLVERR;
  bytes = 64'd1 << size;
  beats = 64'(len) + 64'd1;
  lo    = 64'(addr);
  if (lo % bytes != 0) return RESP_SLVERR;
  case (burst)
    BURST_FIXED: hi = lo + bytes;
    BURST_INCR:  hi = lo + beats * bytes;
    BURST_WRAP: begin
      if (!(beats inside {64'd2, 64'd4, 64'd8, 64'd16})) return RESP_SLVERR;
      lo = lo - lo % (beats * bytes);  // window start
      hi = lo + beats * bytes;
    end
    default: return RESP_SLVERR;
  endcase
  if (hi > MEM_BYTES) return RESP_DECERR;
  return RESP_OKAY;
endfunction

// address of the beat after a
function automatic addr_t beat_step(addr_t a, len_t len, size_t size, burst_t burst);
  addr_t incr;
  addr_t win;
  addr_t lo;
  incr = addr_t'(1) << size;
  win  = (addr_t'(len) + addr_t'(1)) << size;
  lo   = a - a % win;
  case (burst)
    BURST_INCR: return a + incr;
    BURST_WRAP: return lo + (a + incr - lo) % win;
    default:    return a;
  endcase
endfunction

task automatic model_write_beat(addr_t a, data_t d, strb_t s, size_t size);
  for (int k = 0; k < (1 << size); k++) begin
    if (s[k]) model_mem[int'(a) + k] = d[8*k +: 8];
  end
endtask

function automatic data_t model_read_beat(addr_t a, size_t size);
  data_t d;
  d = '0;  // unused lanes stay zero
  for (int k = 0; k < (1 << size); k++) begin
    d[8*k +: 8] = model_mem[int'(a) + k];
  end
  return d;
endfunction

//////////////////////////////
// compares
task automatic check_resp(string name, resp_t exp, resp_t got);
  if (got !== exp)
    stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
endtask

task automatic check_id(string name, id_t exp, id_t got);
  if (got !== exp)
    stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
endtask

task automatic check_data(string name, data_t exp, data_t got);
  if (got !== exp)
    stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
endtask

task automatic check_last(string name, logic exp, logic got);
  if (got !== exp)
    stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
endtask

task automatic check_flag(string name, logic exp, logic got);
  if (got !== exp)
    stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got));
endtask

`endif

// File: tb/axi_mem_slave_tb.sv
/* AXI memory slave testbench */

`timescale 1ns/1ps

module axi_mem_slave_tb;
  import axi_slave_pkg::*;

  localparam int unsigned MEM_BYTES = 128;
  localparam int TIMEOUT = 200;  // cycles per wait

  logic   clk;
  logic   resetn;
  logic   awvalid;
  logic   awready;
  id_t    awid;
  addr_t  awaddr;
  len_t   awlen;
  size_t  awsize;
  burst_t awburst;
  logic   wvalid;
  logic   wready;
  data_t  wdata;
  strb_t  wstrb;
  logic   wlast;
  logic   bvalid;
  logic   bready;
  id_t    bid;
  resp_t  bresp;
  logic   arvalid;
  logic   arready;
  id_t    arid;
  addr_t  araddr;
  len_t   arlen;
  size_t  arsize;
  burst_t arburst;
  logic   rvalid;
  logic   rready;
  id_t    rid;
  data_t  rdata;
  resp_t  rresp;
  logic   rlast;

  axi_mem_slave #(.MEM_BYTES(MEM_BYTES)) i_axi_mem_slave (.*);

  `include "axi_mem_model.svh"

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // bus drivers, all on the falling edge
  task automatic write_burst(id_t id, addr_t addr, len_t len, size_t size, burst_t burst,
                             bit full_strb);
    resp_t exp;
    addr_t baddr;
    int    beat;
    int    wait_cnt;
    exp      = expected_resp(addr, len, size, burst);
    awid     = id;
    awaddr   = addr;
    awlen    = len;
    awsize   = size;
    awburst  = burst;
    awvalid  = 1'b1;
    wait_cnt = 0;
    while (!awready) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT) stop_on_error("Timeout waiting for awready");
      @(negedge clk);
    end
    @(negedge clk);
    awvalid  = 1'b0;
    baddr    = addr;
    beat     = 0;
    wait_cnt = 0;
    while (beat <= len) begin
      wvalid = ($urandom % 4) != 0;  // random idle cycles
      wdata  = $urandom;
      wstrb  = full_strb ? 4'hf : strb_t'($urandom);
      wlast  = (beat == len);
      if (wvalid && wready) begin
        if (exp == RESP_OKAY) model_write_beat(baddr, wdata, wstrb, size);
        baddr    = beat_step(baddr, len, size, burst);
        beat++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) stop_on_error("Timeout waiting for wready");
      end
      @(negedge clk);
    end
    wvalid   = 1'b0;
    wlast    = 1'b0;
    wait_cnt = 0;
    bready   = ($urandom % 3) != 0;
    while (!(bvalid && bready)) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT) stop_on_error("Timeout waiting for the write response");
      @(negedge clk);
      bready = ($urandom % 3) != 0;
    end
    check_id("bid", id, bid);
    check_resp("bresp", exp, bresp);
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic read_burst(id_t id, addr_t addr, len_t len, size_t size, burst_t burst);
    resp_t exp;
    addr_t baddr;
    data_t exp_data;
    data_t hold_data;
    logic  hold_last;
    bit    held;
    int    beat;
    int    wait_cnt;
    exp      = expected_resp(addr, len, size, burst);
    arid     = id;
    araddr   = addr;
    arlen    = len;
    arsize   = size;
    arburst  = burst;
    arvalid  = 1'b1;
    wait_cnt = 0;
    while (!arready) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT) stop_on_error("Timeout waiting for arready");
      @(negedge clk);
    end
    @(negedge clk);
    arvalid  = 1'b0;
    baddr    = addr;
    beat     = 0;
    held     = 1'b0;
    wait_cnt = 0;
    while (beat <= len) begin
      rready = ($urandom % 3) != 0;
      if (held) begin  // stalled beat must not move
        check_flag("rvalid", 1'b1, rvalid);
        check_data("rdata", hold_data, rdata);
        check_last("rlast", hold_last, rlast);
      end
      if (rvalid && rready) begin
        exp_data = (exp == RESP_OKAY) ? model_read_beat(baddr, size) : '0;
        check_data("rdata", exp_data, rdata);
        check_resp("rresp", exp, rresp);
        check_id("rid", id, rid);
        check_last("rlast", beat == len, rlast);
        baddr    = beat_step(baddr, len, size, burst);
        beat++;
        held     = 1'b0;
        wait_cnt = 0;
      end else begin
        held      = rvalid;
        hold_data = rdata;
        hold_last = rlast;
        wait_cnt++;
        if (wait_cnt > TIMEOUT) stop_on_error("Timeout waiting for a read beat");
      end
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  task automatic pick_okay_burst(output addr_t addr, output len_t len, output size_t size,
                                 output burst_t burst);
    do begin
      size  = size_t'($urandom % 3);
      burst = burst_t'($urandom % 3);
      len   = (burst == BURST_WRAP) ? len_t'((2 << ($urandom % 4)) - 1) : len_t'($urandom % 16);
      addr  = addr_t'($urandom % MEM_BYTES) & ~((addr_t'(1) << size) - addr_t'(1));
    end while (expected_resp(addr, len, size, burst) != RESP_OKAY);
  endtask

  task automatic error_burst(addr_t addr, len_t len, size_t size, burst_t burst);
    write_burst(id_t'($urandom), addr, len, size, burst, 1'b0);
    read_burst(id_t'($urandom), addr, len, size, burst);
  endtask

  task automatic read_all;
    read_burst(id_t'($urandom), 32'd0, 4'd15, 3'd2, BURST_INCR);
    read_burst(id_t'($urandom), 32'd64, 4'd15, 3'd2, BURST_INCR);
  endtask

  //////////////////////////////
  // run sequence
  initial begin
    addr_t  a;
    len_t   l;
    size_t  s;
    burst_t b;
    void'($urandom(32'h1e01));
    resetn  = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = BURST_FIXED;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = '0;
    arburst = BURST_FIXED;
    rready  = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (16) begin
      @(negedge clk);
      check_flag("awready", 1'b0, awready);
      check_flag("wready", 1'b0, wready);
      check_flag("bvalid", 1'b0, bvalid);
      check_flag("arready", 1'b0, arready);
      check_flag("rvalid", 1'b0, rvalid);
    end
    resetn = 1'b1;
    @(negedge clk);
    check_flag("wready", 1'b0, wready);
    check_flag("bvalid", 1'b0, bvalid);
    check_flag("rvalid", 1'b0, rvalid);
    read_all();  // untouched memory
    repeat (60) begin
      pick_okay_burst(a, l, s, b);
      write_burst(id_t'($urandom), a, l, s, b, 1'b1);
      read_burst(id_t'($urandom), a, l, s, b);
    end
    repeat (40) begin  // partial strobes
      pick_okay_burst(a, l, s, b);
      write_burst(id_t'($urandom), a, l, s, b, 1'b0);
      read_burst(id_t'($urandom), a, l, s, b);
    end
    error_burst(32'd1, 4'd3, 3'd1, BURST_INCR);     // misaligned
    error_burst(32'd8, 4'd0, 3'd3, BURST_INCR);     // size 3
    error_burst(32'd0, 4'd2, 3'd2, BURST_WRAP);     // 3-beat wrap
    error_burst(32'd0, 4'd0, 3'd0, burst_t'(2'b11));
    error_burst(32'd120, 4'd3, 3'd2, BURST_INCR);   // runs past the end
    error_burst(32'd200, 4'd3, 3'd1, BURST_WRAP);
    error_burst(32'd128, 4'd0, 3'd2, BURST_FIXED);
    read_all();
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: axi_mem_slave.f
+incdir+tb
hw/axi_slave_pkg.sv
hw/burst_addr_gen.sv
hw/byte_mem.sv
hw/write_channel.sv
hw/read_channel.sv
hw/axi_mem_slave.sv
tb/axi_mem_slave_tb.sv
